// File: Makefile
# Verilator build and run for the RC4 core testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_rc4
FILELIST  := project.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: design/keystream_gen.sv
/* RC4 pseudo-random generation, one keystream byte per accepted request */
`timescale 1ns/1ps

module keystream_gen (
    input  logic               clk,
    input  logic               reset,
    input  logic               enable,
    input  logic               ks_req,
    input  rc4_pkg::rc4_byte_t ram_out,
    output rc4_pkg::ram_req_t  req,
    output logic               ready,
    output logic               ks_valid,
    output rc4_pkg::rc4_byte_t ks_byte
);
    import rc4_pkg::*;

    gen_state_t state;
    rc4_byte_t  i;
    rc4_byte_t  j;
    rc4_byte_t  si;
    rc4_byte_t  sj;
    rc4_byte_t  next_j;
    rc4_byte_t  t_addr;

    assign next_j = j + ram_out;   // ram_out is s[i] in GEN_READ_J
    assign t_addr = si + sj;
    assign ready  = enable && (state == GEN_IDLE);

    always_comb begin
        req = '0;
        case (state)
            GEN_READ_I:  req.addr = i;
            GEN_READ_J:  req.addr = next_j;
            GEN_WRITE_I: begin
                req.addr  = i;
                req.wdata = ram_out;   // old s[j]
                req.we    = 1'b1;
            end
            GEN_WRITE_J: begin
                req.addr  = j;
                req.wdata = si;
                req.we    = 1'b1;
            end
            GEN_READ_T:  req.addr = t_addr;
            default:     req = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= GEN_IDLE;
            i        <= '0;
            j        <= '0;
            ks_valid <= 1'b0;
        end else begin
            ks_valid <= 1'b0;
            if (!enable) begin
                // stream restarts from i = j = 0 on the next run
                state <= GEN_IDLE;
                i     <= '0;
                j     <= '0;
            end else begin
                case (state)
                    GEN_IDLE: begin
                        if (ks_req) begin
                            i     <= i + 8'd1;
                            state <= GEN_READ_I;
                        end
                    end
                    GEN_READ_I:  state <= GEN_READ_J;
                    GEN_READ_J: begin
                        j     <= next_j;
                        state <= GEN_WRITE_I;
                    end
                    GEN_WRITE_I: state <= GEN_WRITE_J;
                    GEN_WRITE_J: state <= GEN_READ_T;
                    GEN_READ_T:  state <= GEN_OUT;
                    GEN_OUT: begin
                        ks_valid <= 1'b1;
                        state    <= GEN_IDLE;
                    end
                    default:     state <= GEN_IDLE;
                endcase
            end
        end
    end

    // swap operands and output byte
    always_ff @(posedge clk) begin
        if (state == GEN_READ_J) begin
            si <= ram_out;
        end
        if (state == GEN_WRITE_I) begin
            sj <= ram_out;
        end
        if (state == GEN_OUT) begin
            ks_byte <= ram_out;
        end
    end

endmodule

// File: design/ram_shuffler.sv
/* RC4 key-scheduling shuffle over the state RAM, four cycles per index
   in a read phase and a write phase */
`timescale 1ns/1ps

module ram_shuffler #(
    parameter int KEY_LENGTH = 3
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                start,
    input  rc4_pkg::rc4_byte_t [KEY_LENGTH-1:0] key,
    input  rc4_pkg::rc4_byte_t                  ram_out,
    output rc4_pkg::ram_req_t                   req,
    output logic                                finished
);
    import rc4_pkg::*;

    shuffle_state_t state;
    logic           start_q;
    logic           start_sig;
    logic           rd_tog;     // 0: read s[i], 1: read s[j]
    logic           wr_tog;     // 0: write s[i], 1: write s[j]
    rc4_byte_t      i;
    rc4_byte_t      j;
    rc4_byte_t      si;
    rc4_byte_t      next_j;
    rc4_byte_t      key_byte;

    // rising edge of start
    assign start_sig = start && !start_q;

    // top key element goes with i = 0
    assign key_byte = key[KEY_LENGTH - 1 - (i % KEY_LENGTH)];

    // wraps mod 256 through the byte width
    assign next_j = j + ram_out + key_byte;

    /*
     * read phase presents i, then the new j while s[i] is on ram_out
     * write phase stores s[j] into s[i] straight from ram_out,
     * then the saved s[i] into s[j]
     */
    always_comb begin
        req = '0;
        case (state)
            SH_READ: begin
                req.addr = rd_tog ? next_j : i;
            end
            SH_WRITE: begin
                req.we    = 1'b1;
                req.addr  = wr_tog ? j : i;
                req.wdata = wr_tog ? si : ram_out;
            end
            default: begin
                req = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= SH_AWAIT_START;
            start_q  <= 1'b0;
            rd_tog   <= 1'b0;
            wr_tog   <= 1'b0;
            i        <= '0;
            j        <= '0;
            finished <= 1'b0;
        end else begin
            start_q  <= start;
            finished <= 1'b0;
            if (start_sig) begin
                // a new start always begins from index 0
                state  <= SH_READ;
                rd_tog <= 1'b0;
                wr_tog <= 1'b0;
                i      <= '0;
                j      <= '0;
            end else begin
                case (state)
                    SH_READ: begin
                        rd_tog <= ~rd_tog;
                        if (rd_tog) begin
                            j     <= next_j;
                            state <= SH_WRITE;
                        end
                    end
                    SH_WRITE: begin
                        wr_tog <= ~wr_tog;
                        if (wr_tog) begin
                            if (i == 8'hFF) begin
                                state    <= SH_AWAIT_START;
                                finished <= 1'b1;
                                i        <= '0;
                                j        <= '0;
                            end else begin
                                i     <= i + 8'd1;
                                state <= SH_READ;
                            end
                        end
                    end
                    default: begin
                        state <= SH_AWAIT_START;
                    end
                endcase
            end
        end
    end

    // s[i] kept for the second swap write
    always_ff @(posedge clk) begin
        if (state == SH_READ && rd_tog) begin
            si <= ram_out;
        end
    end

endmodule

// File: design/rc4_controller.sv
/* RC4 phase sequencer: init, shuffle and generate, with the state RAM
   port routed to the active phase */
`timescale 1ns/1ps

module rc4_controller #(
    parameter int KEY_LENGTH = 3
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                start,
    input  rc4_pkg::rc4_byte_t [KEY_LENGTH-1:0] key,
    input  logic                                ks_req,
    output logic                                ready,
    output logic                                ks_valid,
    output rc4_pkg::rc4_byte_t                  ks_byte
);
    import rc4_pkg::*;

    phase_t    phase;
    logic      init_start;
    logic      init_done;
    logic      shuffle_start;
    logic      finished;
    logic      gen_enable;
    ram_req_t  init_req;
    ram_req_t  shuf_req;
    ram_req_t  gen_req;
    ram_req_t  ram_req;
    rc4_byte_t ram_rdata;

    assign gen_enable = (phase == PH_GENERATE);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase         <= PH_IDLE;
            init_start    <= 1'b0;
            shuffle_start <= 1'b0;
        end else begin
            init_start    <= 1'b0;
            shuffle_start <= 1'b0;
            if (start) begin
                phase      <= PH_INIT;   // also restarts a run in progress
                init_start <= 1'b1;
            end else begin
                case (phase)
                    PH_INIT: begin
                        // a done left over from an aborted run is dropped
                        if (init_done && !init_start) begin
                            phase         <= PH_SHUFFLE;
                            shuffle_start <= 1'b1;
                        end
                    end
                    PH_SHUFFLE: begin
                        if (finished && !shuffle_start) begin
                            phase <= PH_GENERATE;
                        end
                    end
                    default: phase <= phase;
                endcase
            end
        end
    end

    // route the active phase, no writes while its block is being restarted
    always_comb begin
        case (phase)
            PH_INIT:     ram_req = init_req;
            PH_SHUFFLE:  ram_req = shuf_req;
            PH_GENERATE: ram_req = gen_req;
            default:     ram_req = '0;
        endcase
        if (init_start || shuffle_start) begin
            ram_req.we = 1'b0;
        end
    end

    state_ram u_state_ram (
        .clk   (clk),
        .req   (ram_req),
        .rdata (ram_rdata)
    );

    sbox_init u_sbox_init (
        .clk   (clk),
        .reset (reset),
        .start (init_start),
        .req   (init_req),
        .done  (init_done)
    );

    ram_shuffler #(
        .KEY_LENGTH (KEY_LENGTH)
    ) u_ram_shuffler (
        .clk      (clk),
        .reset    (reset),
        .start    (shuffle_start),
        .key      (key),
        .ram_out  (ram_rdata),
        .req      (shuf_req),
        .finished (finished)
    );

    keystream_gen u_keystream_gen (
        .clk      (clk),
        .reset    (reset),
        .enable   (gen_enable),
        .ks_req   (ks_req),
        .ram_out  (ram_rdata),
        .req      (gen_req),
        .ready    (ready),
        .ks_valid (ks_valid),
        .ks_byte  (ks_byte)
    );

endmodule

// File: design/rc4_core.sv
/* RC4 stream cipher core, top level of the design */
`timescale 1ns/1ps

module rc4_core #(
    parameter int KEY_LENGTH = 3   // key bytes, fixed per build
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                start,
    // first key byte sits in element KEY_LENGTH-1
    input  rc4_pkg::rc4_byte_t [KEY_LENGTH-1:0] key,
    input  logic                                ks_req,
    output logic                                ready,
    output logic                                ks_valid,
    output rc4_pkg::rc4_byte_t                  ks_byte
);

    rc4_controller #(
        .KEY_LENGTH (KEY_LENGTH)
    ) u_rc4_controller (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .key      (key),
        .ks_req   (ks_req),
        .ready    (ready),
        .ks_valid (ks_valid),
        .ks_byte  (ks_byte)
    );

endmodule

// File: design/rc4_pkg.sv
/* shared RC4 types: S-box byte, RAM port request and the phase,
   shuffler and generator state encodings */
package rc4_pkg;

    // one S-box entry, also used as an index
    typedef logic [7:0] rc4_byte_t;

    // single RAM port request, read when we is low
    typedef struct packed {
        rc4_byte_t addr;
        rc4_byte_t wdata;
        logic      we;
    } ram_req_t;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_INIT,
        PH_SHUFFLE,
        PH_GENERATE
    } phase_t;

    typedef enum logic [1:0] {
        SH_AWAIT_START,
        SH_READ,    // read s[i], then s[j]
        SH_WRITE    // write s[i], then s[j]
    } shuffle_state_t;

    typedef enum logic [2:0] {
        GEN_IDLE,
        GEN_READ_I,
        GEN_READ_J,
        GEN_WRITE_I,
        GEN_WRITE_J,
        GEN_READ_T,
        GEN_OUT
    } gen_state_t;

endpackage

// File: design/sbox_init.sv
/* S-box initialisation, writes s[k] = k for all 256 entries */
`timescale 1ns/1ps

module sbox_init (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    output rc4_pkg::ram_req_t req,
    output logic              done
);
    import rc4_pkg::*;

    rc4_byte_t cnt;
    logic      busy;

    // one identity write per cycle while busy
    always_comb begin
        req.addr  = cnt;
        req.wdata = cnt;
        req.we    = busy;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt  <= '0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= busy && (cnt == 8'hFF) && !start;
            if (start) begin
                cnt  <= '0;  // restart from entry 0
                busy <= 1'b1;
            end else if (busy) begin
                cnt <= cnt + 8'd1;
                if (cnt == 8'hFF) begin
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

// File: design/state_ram.sv
/* 256 x 8 single-port synchronous RAM holding the RC4 S-box */
`timescale 1ns/1ps

module state_ram (
    input  logic               clk,
    input  rc4_pkg::ram_req_t  req,
    output rc4_pkg::rc4_byte_t rdata
);
    import rc4_pkg::*;

    rc4_byte_t mem [256];

    // data for the address shows up on the next cycle
    always_ff @(posedge clk) begin
        if (req.we) begin
            mem[req.addr] <= req.wdata;
        end
        rdata <= mem[req.addr]; // old contents on a write cycle
    end

endmodule

// File: project.f
design/rc4_pkg.sv
design/state_ram.sv
design/sbox_init.sv
design/ram_shuffler.sv
design/keystream_gen.sv
design/rc4_controller.sv
design/rc4_core.sv
verif/tb_rc4.sv

// File: verif/rc4_vectors.txt
# name key0 key1 key2 count nexp expected... (key and expected bytes in hex)
# key0 is the first key byte, nexp 0 means the testbench model gives the bytes
kat_key 4b 65 79 10 10 eb 9f 77 81 b7 34 ca 72 a7 19
rand_a 3c d1 07 32 0
rand_b 9e 42 f5 32 0
rand_c 01 b8 6a 32 0

// File: verif/tb_rc4.sv
/* RC4 core testbench with vector file reader, reference model
   and keystream checks */
`timescale 1ns/1ps

module tb_rc4;
    import rc4_pkg::*;

    localparam int KEY_LENGTH = 3;
    localparam int MAX_REC    = 8;
    localparam int MAX_EXP    = 16;

    logic                       clk;
    logic                       reset;
    logic                       start;
    rc4_byte_t [KEY_LENGTH-1:0] key;
    logic                       ks_req;
    logic                       ready;
    logic                       ks_valid;
    rc4_byte_t                  ks_byte;

    // records from the vector file
    string     rec_name  [MAX_REC];
    rc4_byte_t rec_key   [MAX_REC][KEY_LENGTH];
    int        rec_count [MAX_REC];
    int        rec_nexp  [MAX_REC];
    rc4_byte_t rec_exp   [MAX_REC][MAX_EXP];
    int        num_rec;
    rc4_byte_t model_ks  [256];   // reference keystream

    rc4_core #(
        .KEY_LENGTH (KEY_LENGTH)
    ) u_rc4_core (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .key      (key),
        .ks_req   (ks_req),
        .ready    (ready),
        .ks_valid (ks_valid),
        .ks_byte  (ks_byte)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic read_vectors();
        int               fd;
        int               code;
        int               cnt;
        int               nexp;
        logic [8*32-1:0]  tok;
        logic [8*256-1:0] rest;
        rc4_byte_t        b;
        fd = $fopen("verif/rc4_vectors.txt", "r");
        if (fd == 0) fail_run("could not open the vector file verif/rc4_vectors.txt");
        num_rec = 0;
        code = $fscanf(fd, "%s", tok);
        while (code == 1) begin
            if (tok[7:0] == "#" && tok[15:8] == 8'h00) begin
                code = $fgets(rest, fd);   // skip comment line
            end else begin
                if (num_rec >= MAX_REC) fail_run("too many records in the vector file");
                rec_name[num_rec] = string'(tok);
                for (int e = 0; e < KEY_LENGTH; e++) begin
                    code = $fscanf(fd, "%h", b);
                    rec_key[num_rec][e] = b;
                end
                code = $fscanf(fd, "%d %d", cnt, nexp);
                if (code != 2 || nexp > MAX_EXP || cnt > 256) begin
                    fail_run($sformatf("malformed record %s in the vector file", string'(tok)));
                end
                rec_count[num_rec] = cnt;
                rec_nexp[num_rec]  = nexp;
                for (int e = 0; e < nexp; e++) begin
                    code = $fscanf(fd, "%h", b);
                    rec_exp[num_rec][e] = b;
                end
                num_rec++;
            end
            code = $fscanf(fd, "%s", tok);
        end
        $fclose(fd);
        if (num_rec < 3) fail_run("the vector file holds fewer than three records");
    endtask

    // plain RC4 with the first key byte at i = 0
    task automatic compute_stream(input int r, input int n);
        rc4_byte_t s [256];
        rc4_byte_t tmp;
        rc4_byte_t ii;
        rc4_byte_t jj;
        for (int k = 0; k < 256; k++) s[k] = 8'(k);
        jj = 8'd0;
        for (int k = 0; k < 256; k++) begin
            jj    = jj + s[k] + rec_key[r][k % KEY_LENGTH];
            tmp   = s[k];
            s[k]  = s[jj];
            s[jj] = tmp;
        end
        ii = 8'd0;
        jj = 8'd0;
        for (int k = 0; k < n; k++) begin
            ii          = ii + 8'd1;
            jj          = jj + s[ii];
            tmp         = s[ii];
            s[ii]       = s[jj];
            s[jj]       = tmp;
            model_ks[k] = s[8'(s[ii] + s[jj])];
        end
    endtask

    task automatic check_quiet(input string name);
        assert (!ready && !ks_valid) else begin
            fail_run($sformatf("error: %s ready/ks_valid expected 0/0 actual %0b/%0b",
                               name, ready, ks_valid));
        end
    endtask

    task automatic start_run(input int r);
        for (int e = 0; e < KEY_LENGTH; e++) key[KEY_LENGTH-1-e] = rec_key[r][e];
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    // stray requests while not ready must be dropped
    task automatic wait_ready(input string name);
        int cycles;
        cycles = 0;
        while (!ready) begin
            assert (!ks_valid) else begin
                fail_run($sformatf("error: %s ks_valid expected 0 actual 1 before ready", name));
            end
            ks_req = ($urandom % 4 == 0);
            @(negedge clk);
            cycles++;
            if (cycles > 2000) fail_run($sformatf("timeout waiting for ready in %s", name));
        end
        ks_req = 1'b0;
    endtask

    task automatic busy_cycles(input string name, input int n);
        for (int c = 0; c < n; c++) begin
            check_quiet(name);
            ks_req = ($urandom % 4 == 0);
            @(negedge clk);
        end
        ks_req = 1'b0;
    endtask

    task automatic request_byte(input string name, input int idx, input rc4_byte_t exp);
        int cycles;
        assert (ready) else begin
            fail_run($sformatf("error: %s ready expected 1 actual 0 before request %0d",
                               name, idx));
        end
        ks_req = 1'b1;
        @(negedge clk);
        ks_req = 1'b0;
        cycles = 0;
        while (!ks_valid) begin
            ks_req = !ready && ($urandom % 3 == 0);  // ignored while busy
            @(negedge clk);
            cycles++;
            if (cycles > 40) fail_run($sformatf("timeout waiting for ks_valid in %s", name));
        end
        ks_req = 1'b0;
        assert (ks_byte == exp) else begin
            fail_run($sformatf("error: %s byte %0d expected %02h actual %02h",
                               name, idx, exp, ks_byte));
        end
    endtask

    task automatic run_stream(input string name, input int r, input int n);
        compute_stream(r, n);
        for (int e = 0; e < rec_nexp[r] && e < n; e++) begin
            assert (model_ks[e] == rec_exp[r][e]) else begin
                fail_run($sformatf("error: %s model byte %0d expected %02h actual %02h",
                                   name, e, rec_exp[r][e], model_ks[e]));
            end
        end
        for (int e = 0; e < n; e++) request_byte(name, e, model_ks[e]);
    endtask

    initial begin
        reset  = 1'b1;
        start  = 1'b0;
        ks_req = 1'b0;
        key    = '0;
        void'($urandom(66574));
        read_vectors();
        repeat (16) begin
            @(negedge clk);
            check_quiet("reset");
        end
        reset = 1'b0;
        @(negedge clk);
        check_quiet("after_reset");

        // known answer first and each later key without reset
        for (int r = 0; r < num_rec; r++) begin
            start_run(r);
            wait_ready(rec_name[r]);
            run_stream(rec_name[r], r, rec_count[r]);
        end

        // init is 256 cycles so 600 lands inside the shuffle
        start_run(0);
        busy_cycles("mid_shuffle", 600);
        start_run(1);
        wait_ready("restart");
        run_stream("restart", 1, 16);

        // reset in the generate phase
        reset = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_quiet("reset_mid_run");
        end
        reset = 1'b0;
        @(negedge clk);
        check_quiet("after_mid_reset");
        start_run(2);
        wait_ready("post_reset");
        run_stream("post_reset", 2, 8);

        $display("Test completed successfully");
        $finish;
    end

endmodule
